/* source/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Word and bus width
`define CPU_DATA_WIDTH 32

// General register file
`define CPU_REG_COUNT 16
`define CPU_REG_INDEX_WIDTH 4

// Word-addressed program memory
`define CPU_MEM_DEPTH 256
`define CPU_ADDR_WIDTH 8

// Instruction fields
`define CPU_OPCODE_WIDTH 5
`define CPU_IMM_WIDTH 19
`define CPU_IMM_LOW_WIDTH 15

// T-state index
`define CPU_STEP_WIDTH 3

`endif

/* source/cpuPkg.sv */
`default_nettype none
`include "cpu_config.svh"

package cpuPkg;

    typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
        opLdi  = 5'b00001,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opMfhi = 5'b11000,
        opMflo = 5'b11001,
        opHalt = 5'b11011
    } opcodeT;

    // Full immediate is {rc, imm}, sign extended from the top bit of rc
    typedef struct packed {
        opcodeT                          opcode;
        logic [`CPU_REG_INDEX_WIDTH-1:0] ra;
        logic [`CPU_REG_INDEX_WIDTH-1:0] rb;
        logic [`CPU_REG_INDEX_WIDTH-1:0] rc;
        logic [`CPU_IMM_LOW_WIDTH-1:0]   imm;
    } instrT;

    typedef logic [`CPU_STEP_WIDTH-1:0] stepT;

    typedef struct packed {
        // Bus sources
        logic pcOut;
        logic mdrOut;
        logic zLowOut;
        logic hiOut;
        logic loOut;
        logic cOut;
        logic rOut;
        // Register loads
        logic marIn;
        logic mdrIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic rIn;
        logic incPc;
        logic pcLoad;
        // Register index selects
        logic gra;
        logic grb;
        logic grc;
        // Memory read and ALU operation
        logic read;
        logic subtract;
    } ctrlT;

    typedef struct packed {
        logic                       req;
        logic [`CPU_ADDR_WIDTH-1:0] startPc;
        logic [`CPU_DATA_WIDTH-1:0] hiValue;
        logic [`CPU_DATA_WIDTH-1:0] loValue;
    } runReqT;

    typedef struct packed {
        logic                       enable;
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        logic [`CPU_DATA_WIDTH-1:0] data;
    } loadT;

endpackage

`default_nettype wire

/* source/stepCounter.sv */
`default_nettype none

module stepCounter
    import cpuPkg::*;
(
    input  logic Clock,
    input  logic arstN,
    input  logic clear,
    input  logic advance,
    output stepT step
);

    stepT count;

    // Clear wins over advance so the last step of an instruction returns to T0
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (advance) begin
            count <= count + 1'b1;
        end
    end

    assign step = count;

    // The sequencer must halt or clear before the counter runs off its range
    property noWrap;
        @(posedge Clock) disable iff (!arstN)
            (advance && !clear) |-> (count != '1);
    endproperty

    noWrapCheck: assert property (noWrap)
        else $error("stepCounter advanced past the last T-state");

endmodule

`default_nettype wire

/* source/controlSequencer.sv */
`default_nettype none

module controlSequencer
    import cpuPkg::*;
(
    input  logic   Clock,
    input  logic   arstN,
    input  runReqT runReq,
    output logic   runAck,
    input  stepT   step,
    input  opcodeT opcode,
    output ctrlT   ctrl,
    output logic   stepClear,
    output logic   stepAdvance,
    output logic   startLatch
);

    typedef enum logic [1:0] {
        stIdle,
        stStart,
        stExecute,
        stDone
    } runStateT;

    runStateT state;
    runStateT stateNext;
    logic     lastStep;
    logic     halting;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    // Strobes for each T-state of the current instruction
    always_comb begin
        ctrl = '0;
        lastStep = 1'b0;
        halting = 1'b0;
        if (state == stExecute) begin
            case (step)
                3'd0: begin
                    ctrl.pcOut = 1'b1;
                    ctrl.marIn = 1'b1;
                    ctrl.incPc = 1'b1;
                end
                3'd1: begin
                    ctrl.read = 1'b1;
                    ctrl.mdrIn = 1'b1;
                end
                3'd2: begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.irIn = 1'b1;
                end
                3'd3: begin
                    case (opcode)
                        opLdi, opMfhi, opMflo: begin
                            ctrl.cOut = (opcode == opLdi);
                            ctrl.hiOut = (opcode == opMfhi);
                            ctrl.loOut = (opcode == opMflo);
                            ctrl.gra = 1'b1;
                            ctrl.rIn = 1'b1;
                            lastStep = 1'b1;
                        end
                        opAdd, opSub: begin
                            ctrl.grb = 1'b1;
                            ctrl.rOut = 1'b1;
                            ctrl.yIn = 1'b1;
                        end
                        // HALT and any unknown opcode
                        default: halting = 1'b1;
                    endcase
                end
                // Only ADD and SUB reach T4 and T5
                3'd4: begin
                    ctrl.grc = 1'b1;
                    ctrl.rOut = 1'b1;
                    ctrl.zIn = 1'b1;
                    ctrl.subtract = (opcode == opSub);
                end
                3'd5: begin
                    ctrl.zLowOut = 1'b1;
                    ctrl.gra = 1'b1;
                    ctrl.rIn = 1'b1;
                    lastStep = 1'b1;
                end
                default: halting = 1'b1;
            endcase
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:    if (runReq.req) stateNext = stStart;
            stStart:   stateNext = stExecute;
            stExecute: if (halting) stateNext = stDone;
            stDone:    if (!runReq.req) stateNext = stIdle;
            default:   stateNext = stIdle;
        endcase
    end

    assign startLatch = (state == stStart);
    assign stepClear = startLatch || lastStep || halting;
    assign stepAdvance = (state == stExecute) && !lastStep && !halting;
    assign runAck = (state == stDone);

    busSourceCheck: assert property (@(posedge Clock) disable iff (!arstN)
        $onehot0({ctrl.pcOut, ctrl.mdrOut, ctrl.zLowOut, ctrl.hiOut,
                  ctrl.loOut, ctrl.cOut, ctrl.rOut}))
        else $error("More than one bus source strobe active");

    // Ack must have dropped one clock after the host released req
    ackReleaseCheck: assert property (@(posedge Clock) disable iff (!arstN)
        !runReq.req [*2] |-> !runAck)
        else $error("runAck still high after req stayed low");

endmodule

`default_nettype wire

/* source/registerFile.sv */
`default_nettype none
`include "cpu_config.svh"

module registerFile
    import cpuPkg::*;
(
    input  logic                            Clock,
    input  logic                            arstN,
    input  ctrlT                            ctrl,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] ra,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] rb,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] rc,
    input  logic [`CPU_DATA_WIDTH-1:0]      bus,
    output logic [`CPU_DATA_WIDTH-1:0]      busData,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] regReadIndex,
    output logic [`CPU_DATA_WIDTH-1:0]      regReadData
);

    logic [`CPU_DATA_WIDTH-1:0]      regs [`CPU_REG_COUNT];
    logic [`CPU_REG_INDEX_WIDTH-1:0] select;

    // Gra, Grb and Grc pick which IR field addresses the file
    always_comb begin
        if (ctrl.gra) begin
            select = ra;
        end else if (ctrl.grb) begin
            select = rb;
        end else if (ctrl.grc) begin
            select = rc;
        end else begin
            select = '0;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rIn) begin
            regs[select] <= bus;
        end
    end

    assign busData = ctrl.rOut ? regs[select] : '0;
    assign regReadData = regs[regReadIndex];

    // Register access needs exactly one index select from the sequencer
    selectCheck: assert property (@(posedge Clock) disable iff (!arstN)
        (ctrl.rIn || ctrl.rOut) |-> $onehot({ctrl.gra, ctrl.grb, ctrl.grc}))
        else $error("Register access without a single index select");

endmodule

`default_nettype wire

/* source/programMemory.sv */
`default_nettype none
`include "cpu_config.svh"

module programMemory
    import cpuPkg::*;
(
    input  logic                       Clock,
    input  loadT                       load,
    input  logic [`CPU_ADDR_WIDTH-1:0] addr,
    output logic [`CPU_DATA_WIDTH-1:0] data
);

    logic [`CPU_DATA_WIDTH-1:0] mem [`CPU_MEM_DEPTH];

    // Host write port
    always_ff @(posedge Clock) begin
        if (load.enable) begin
            mem[load.addr] <= load.data;
        end
    end

    // Core read port with the word valid one cycle after the address
    always_ff @(posedge Clock) begin
        data <= mem[addr];
    end

endmodule

`default_nettype wire

/* source/datapath.sv */
`default_nettype none
`include "cpu_config.svh"

module datapath
    import cpuPkg::*;
(
    input  logic                       Clock,
    input  logic                       arstN,
    input  ctrlT                       ctrl,
    input  runReqT                     runReq,
    input  logic                       startLatch,
    input  logic [`CPU_DATA_WIDTH-1:0] regBusData,
    output logic [`CPU_DATA_WIDTH-1:0] bus,
    output instrT                      instr,
    output logic [`CPU_ADDR_WIDTH-1:0] memAddr,
    input  logic [`CPU_DATA_WIDTH-1:0] memData
);

    logic [`CPU_ADDR_WIDTH-1:0] pc;
    logic [`CPU_ADDR_WIDTH-1:0] mar;
    logic [`CPU_DATA_WIDTH-1:0] mdr;
    instrT                      ir;
    logic [`CPU_DATA_WIDTH-1:0] y;
    logic [`CPU_DATA_WIDTH-1:0] z;
    logic [`CPU_DATA_WIDTH-1:0] hi;
    logic [`CPU_DATA_WIDTH-1:0] lo;
    logic [`CPU_IMM_WIDTH-1:0]  immField;
    logic [`CPU_DATA_WIDTH-1:0] immExt;
    logic [`CPU_DATA_WIDTH-1:0] aluResult;

    assign immField = {ir.rc, ir.imm};
    assign immExt = {{(`CPU_DATA_WIDTH - `CPU_IMM_WIDTH){immField[`CPU_IMM_WIDTH-1]}}, immField};

    // Bus multiplexer selected by the source strobes
    always_comb begin
        bus = '0;
        if (ctrl.pcOut) begin
            bus = {{(`CPU_DATA_WIDTH - `CPU_ADDR_WIDTH){1'b0}}, pc};
        end else if (ctrl.mdrOut) begin
            bus = mdr;
        end else if (ctrl.zLowOut) begin
            bus = z;
        end else if (ctrl.hiOut) begin
            bus = hi;
        end else if (ctrl.loOut) begin
            bus = lo;
        end else if (ctrl.cOut) begin
            bus = immExt;
        end else if (ctrl.rOut) begin
            bus = regBusData;
        end
    end

    assign aluResult = ctrl.subtract ? (y - bus) : (y + bus);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (startLatch) begin
                pc <= runReq.startPc;
            end else if (ctrl.pcLoad) begin
                pc <= bus[`CPU_ADDR_WIDTH-1:0];
            end else if (ctrl.incPc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.irIn) begin
                ir <= instrT'(bus);
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (startLatch) begin
            hi <= runReq.hiValue;
            lo <= runReq.loValue;
        end
        if (ctrl.marIn) begin
            mar <= bus[`CPU_ADDR_WIDTH-1:0];
        end
        if (ctrl.mdrIn) begin
            mdr <= ctrl.read ? memData : bus;
        end
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= aluResult;
        end
    end

    // Memory sees the MAR value being loaded, so the word is ready for MDR in T1
    assign memAddr = ctrl.marIn ? bus[`CPU_ADDR_WIDTH-1:0] : mar;
    assign instr = ir;

    loadSourceCheck: assert property (@(posedge Clock) disable iff (!arstN)
        (ctrl.marIn || ctrl.irIn || ctrl.yIn || ctrl.zIn || ctrl.rIn)
            |-> (ctrl.pcOut || ctrl.mdrOut || ctrl.zLowOut || ctrl.hiOut ||
                 ctrl.loOut || ctrl.cOut || ctrl.rOut))
        else $error("Register loads from an undriven bus");

endmodule

`default_nettype wire

/* source/cpuTop.sv */
`default_nettype none
`include "cpu_config.svh"

module cpuTop
    import cpuPkg::*;
(
    input  logic                            Clock,
    input  logic                            arstN,
    input  runReqT                          runReq,
    output logic                            runAck,
    input  loadT                            load,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] regReadIndex,
    output logic [`CPU_DATA_WIDTH-1:0]      regReadData
);

    ctrlT                       ctrl;
    stepT                       step;
    logic                       stepClear;
    logic                       stepAdvance;
    logic                       startLatch;
    instrT                      instr;
    logic [`CPU_DATA_WIDTH-1:0] bus;
    logic [`CPU_DATA_WIDTH-1:0] regBusData;
    logic [`CPU_ADDR_WIDTH-1:0] memAddr;
    logic [`CPU_DATA_WIDTH-1:0] memData;

    stepCounter stepCounterInst (
        .Clock   (Clock),
        .arstN   (arstN),
        .clear   (stepClear),
        .advance (stepAdvance),
        .step    (step)
    );

    controlSequencer controlSequencerInst (
        .Clock       (Clock),
        .arstN       (arstN),
        .runReq      (runReq),
        .runAck      (runAck),
        .step        (step),
        .opcode      (instr.opcode),
        .ctrl        (ctrl),
        .stepClear   (stepClear),
        .stepAdvance (stepAdvance),
        .startLatch  (startLatch)
    );

    registerFile registerFileInst (
        .Clock        (Clock),
        .arstN        (arstN),
        .ctrl         (ctrl),
        .ra           (instr.ra),
        .rb           (instr.rb),
        .rc           (instr.rc),
        .bus          (bus),
        .busData      (regBusData),
        .regReadIndex (regReadIndex),
        .regReadData  (regReadData)
    );

    programMemory programMemoryInst (
        .Clock (Clock),
        .load  (load),
        .addr  (memAddr),
        .data  (memData)
    );

    datapath datapathInst (
        .Clock      (Clock),
        .arstN      (arstN),
        .ctrl       (ctrl),
        .runReq     (runReq),
        .startLatch (startLatch),
        .regBusData (regBusData),
        .bus        (bus),
        .instr      (instr),
        .memAddr    (memAddr),
        .memData    (memData)
    );

endmodule

`default_nettype wire

/* verification/cpuTb.sv */
`default_nettype none
`include "cpu_config.svh"

module cpuTb
    import cpuPkg::*;
();

    localparam int ackTimeout = 2000;
    localparam int compareTimeout = 100;

    logic                            Clock;
    logic                            arstN;
    runReqT                          runReq;
    logic                            runAck;
    loadT                            load;
    logic [`CPU_REG_INDEX_WIDTH-1:0] regReadIndex;
    logic [`CPU_DATA_WIDTH-1:0]      regReadData;

    logic [`CPU_DATA_WIDTH-1:0] progImage [`CPU_MEM_DEPTH];
    logic [`CPU_DATA_WIDTH-1:0] modelRegs [`CPU_REG_COUNT];
    int                         compareRequests;
    int                         comparesDone;
    integer                     seed;

    cpuTop DUT (
        .Clock        (Clock),
        .arstN        (arstN),
        .runReq       (runReq),
        .runAck       (runAck),
        .load         (load),
        .regReadIndex (regReadIndex),
        .regReadData  (regReadData)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    task automatic failAndStop(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic checkReg(input logic [`CPU_REG_INDEX_WIDTH-1:0] index,
                            input logic [`CPU_DATA_WIDTH-1:0] expected);
        regReadIndex = index;
        @(negedge Clock);
        if (regReadData !== expected) begin
            $display("[FAIL] regReadData[r%h] expected %h got %h", index, expected, regReadData);
            failAndStop("register file read back a wrong value");
        end
    endtask

    task automatic checkAck(input logic expected);
        if (runAck !== expected) begin
            $display("[FAIL] runAck expected %h got %h", expected, runAck);
            failAndStop("run handshake out of step");
        end
    endtask

    function automatic instrT makeInstr(input opcodeT op, input logic [3:0] ra,
                                        input logic [3:0] rb, input logic [3:0] rc,
                                        input logic [14:0] imm);
        instrT word;
        word.opcode = op;
        word.ra = ra;
        word.rb = rb;
        word.rc = rc;
        word.imm = imm;
        return word;
    endfunction

    // The 19-bit immediate spans the rc and imm fields
    function automatic instrT makeLdi(input logic [3:0] ra, input logic [18:0] imm19);
        return makeInstr(opLdi, ra, 4'd0, imm19[18:15], imm19[14:0]);
    endfunction

    // Runs the program on modelRegs and returns the cycles from req to runAck
    function automatic int runModel(input logic [7:0] startPc,
                                    input logic [31:0] hiVal, input logic [31:0] loVal);
        logic [7:0]  pc;
        instrT       ins;
        logic [31:0] imm;
        logic        halted;
        int          cycles;
        pc = startPc;
        halted = 1'b0;
        cycles = 2;
        for (int n = 0; n < `CPU_MEM_DEPTH && !halted; n++) begin
            ins = instrT'(progImage[pc]);
            pc = pc + 8'd1;
            imm = 32'($signed({ins.rc, ins.imm}));
            case (ins.opcode)
                opLdi: modelRegs[ins.ra] = imm;
                opMfhi: modelRegs[ins.ra] = hiVal;
                opMflo: modelRegs[ins.ra] = loVal;
                opAdd: modelRegs[ins.ra] = modelRegs[ins.rb] + modelRegs[ins.rc];
                opSub: modelRegs[ins.ra] = modelRegs[ins.rb] - modelRegs[ins.rc];
                default: halted = 1'b1;
            endcase
            // Three fetch cycles plus three execute cycles for ADD and SUB and one for the rest
            cycles += (ins.opcode == opAdd || ins.opcode == opSub) ? 6 : 4;
        end
        return cycles;
    endfunction

    // Reads back every register whenever a compare is requested
    initial begin
        regReadIndex = '0;
        comparesDone = 0;
        forever begin
            @(negedge Clock);
            if (comparesDone != compareRequests) begin
                for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                    checkReg(4'(i), modelRegs[i]);
                end
                comparesDone++;
            end
        end
    end

    task automatic compareRegisters();
        int waited;
        waited = 0;
        compareRequests++;
        while (comparesDone != compareRequests) begin
            if (waited >= compareTimeout) begin
                failAndStop("timed out waiting for the register compare to finish");
            end
            @(negedge Clock);
            waited++;
        end
    endtask

    task automatic loadWord(input logic [7:0] addr, input instrT word);
        progImage[addr] = word;
        load.enable = 1'b1;
        load.addr = addr;
        load.data = word;
        @(negedge Clock);
        load.enable = 1'b0;
    endtask

    task automatic runProgram(input logic [7:0] startPc,
                              input logic [31:0] hiVal, input logic [31:0] loVal);
        int expectedCycles;
        int cycles;
        expectedCycles = runModel(startPc, hiVal, loVal);
        runReq.startPc = startPc;
        runReq.hiValue = hiVal;
        runReq.loValue = loVal;
        runReq.req = 1'b1;
        cycles = 0;
        while (runAck !== 1'b1) begin
            if (cycles >= ackTimeout) begin
                failAndStop("timed out waiting for runAck to rise");
            end
            @(negedge Clock);
            cycles++;
            checkAck(cycles >= expectedCycles);
        end
        // Holding req keeps the ack up
        repeat (3) begin
            @(negedge Clock);
            checkAck(1'b1);
        end
        runReq.req = 1'b0;
        @(negedge Clock);
        checkAck(1'b0);
        compareRegisters();
    endtask

    initial begin
        logic [18:0] imm19;
        logic [31:0] hiVal;
        logic [31:0] loVal;
        seed = 59642;
        arstN = 1'b0;
        runReq = '0;
        load = '0;
        compareRequests = 0;
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            progImage[i] = '0;
        end
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (16) @(negedge Clock);
        arstN = 1'b1;
        @(negedge Clock);

        checkAck(1'b0);
        compareRegisters();

        // LDI into r1 to r8 with negative immediates for odd targets
        for (int i = 1; i <= 8; i++) begin
            imm19 = 19'($random(seed));
            imm19[18] = (i % 2 == 1);
            loadWord(8'(i - 1), makeLdi(4'(i), imm19));
        end
        loadWord(8'h08, makeInstr(opHalt, 4'd0, 4'd0, 4'd0, 15'd0));

        // Full 32-bit operands come in through HI and LO
        imm19 = 19'($random(seed)) | 19'h40000;
        loadWord(8'h20, makeInstr(opMfhi, 4'd6, 4'd0, 4'd0, 15'd0));
        loadWord(8'h21, makeInstr(opMflo, 4'd7, 4'd0, 4'd0, 15'd0));
        loadWord(8'h22, makeInstr(opAdd, 4'd5, 4'd6, 4'd7, 15'd0));
        loadWord(8'h23, makeInstr(opSub, 4'd8, 4'd7, 4'd6, 15'd0));
        loadWord(8'h24, makeLdi(4'd9, imm19));
        loadWord(8'h25, makeInstr(opAdd, 4'd9, 4'd9, 4'd6, 15'd0));
        loadWord(8'h26, makeInstr(opSub, 4'd6, 4'd6, 4'd9, 15'd0));
        loadWord(8'h27, makeInstr(opAdd, 4'd7, 4'd7, 4'd7, 15'd0));
        loadWord(8'h28, makeInstr(opHalt, 4'd0, 4'd0, 4'd0, 15'd0));

        loadWord(8'h40, makeInstr(opMfhi, 4'd10, 4'd0, 4'd0, 15'd0));
        loadWord(8'h41, makeInstr(opMflo, 4'd11, 4'd0, 4'd0, 15'd0));
        loadWord(8'h42, makeInstr(opMflo, 4'd12, 4'd0, 4'd0, 15'd0));
        loadWord(8'h43, makeInstr(opMfhi, 4'd0, 4'd0, 4'd0, 15'd0));
        loadWord(8'h44, makeInstr(opHalt, 4'd0, 4'd0, 4'd0, 15'd0));

        // Unknown opcode stops the run before the second LDI
        imm19 = 19'($random(seed));
        loadWord(8'h70, makeLdi(4'd14, imm19));
        loadWord(8'h71, instrT'({5'b00111, 27'd0}));
        loadWord(8'h72, makeLdi(4'd15, 19'h12345));
        loadWord(8'h73, makeInstr(opHalt, 4'd0, 4'd0, 4'd0, 15'd0));

        runProgram(8'h00, 32'h0, 32'h0);

        hiVal = $random(seed) | 32'h80000000;
        loVal = $random(seed) | 32'h80000000;
        runProgram(8'h20, hiVal, loVal);

        repeat (3) begin
            hiVal = $random(seed);
            loVal = $random(seed);
            runProgram(8'h40, hiVal, loVal);
        end

        runProgram(8'h70, 32'h0, 32'h0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/cpuPkg.sv
source/stepCounter.sv
source/controlSequencer.sv
source/registerFile.sv
source/programMemory.sv
source/datapath.sv
source/cpuTop.sv
verification/cpuTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f sim.f --top-module cpuTb -Mdir obj_dir -o cpuSim
	./obj_dir/cpuSim

clean:
	rm -rf obj_dir
